/* hdl/chip_pkg.sv */
/*
 * Chip subsystem package
 * Pad and GPIO counts, APB widths and the register map of both targets
 */
`default_nettype none

package chip_pkg;

  // Pad and GPIO counts
  localparam int NMioPads = 8;
  localparam int NGpio    = 8;

  // Select value 1..8 picks source value-1, 0 and 9..15 disconnect
  localparam int PadSelW  = 4;
  localparam int GpioIdxW = $clog2(NGpio);
  localparam int PadIdxW  = $clog2(NMioPads);

  // APB bus
  localparam int ApbAddrW = 12;
  localparam int ApbDataW = 32;

  // Address bits decoded inside a target
  localparam int TgtOffsW = 8;

  // Word stride of per-pad and per-GPIO registers
  localparam int RegStride = 4;

  // Target bases
  localparam logic [ApbAddrW-1:0] GpioBase   = 12'h000;
  localparam logic [ApbAddrW-1:0] PinmuxBase = 12'h100;

  // GPIO registers
  localparam logic [TgtOffsW-1:0] GpioDataOutOffs = 8'h00;
  localparam logic [TgtOffsW-1:0] GpioOeOffs      = 8'h04;
  // Read only
  localparam logic [TgtOffsW-1:0] GpioDataInOffs  = 8'h08;

  // Pinmux registers
  // One word per pad
  localparam logic [TgtOffsW-1:0] MioOutselOffs = 8'h00;
  // One word per GPIO input
  localparam logic [TgtOffsW-1:0] GpioInselOffs = 8'h20;
  // Sticky until reset
  localparam logic [TgtOffsW-1:0] LockOffs      = 8'h40;

endpackage : chip_pkg

`default_nettype wire

/* hdl/apb_fabric.sv */
/*
 * APB fabric
 * Routes the external APB port to the GPIO or pinmux target and merges responses
 */
`timescale 1ns/10ps
`default_nettype none

module apb_fabric (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  // External APB port
  input  logic [chip_pkg::ApbAddrW-1:0] paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [chip_pkg::ApbDataW-1:0] pwdata_i,
  output logic [chip_pkg::ApbDataW-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,

  // GPIO target
  output logic                          gpio_psel_o,
  output logic                          gpio_penable_o,
  output logic [chip_pkg::ApbAddrW-1:0] gpio_paddr_o,
  output logic                          gpio_pwrite_o,
  output logic [chip_pkg::ApbDataW-1:0] gpio_pwdata_o,
  input  logic [chip_pkg::ApbDataW-1:0] gpio_prdata_i,
  input  logic                          gpio_pready_i,
  input  logic                          gpio_pslverr_i,

  // Pinmux register target
  output logic                          pmx_psel_o,
  output logic                          pmx_penable_o,
  output logic [chip_pkg::ApbAddrW-1:0] pmx_paddr_o,
  output logic                          pmx_pwrite_o,
  output logic [chip_pkg::ApbDataW-1:0] pmx_pwdata_o,
  input  logic [chip_pkg::ApbDataW-1:0] pmx_prdata_i,
  input  logic                          pmx_pready_i,
  input  logic                          pmx_pslverr_i
);

  import chip_pkg::*;

  logic gpio_hit;
  logic pmx_hit;
  logic access;

  // Target select from the bits above the in-block offset
  assign gpio_hit = (paddr_i[ApbAddrW-1:TgtOffsW] == GpioBase[ApbAddrW-1:TgtOffsW]);
  assign pmx_hit  = (paddr_i[ApbAddrW-1:TgtOffsW] == PinmuxBase[ApbAddrW-1:TgtOffsW]);
  assign access   = psel_i & penable_i;

  assign gpio_psel_o    = psel_i & gpio_hit;
  assign gpio_penable_o = penable_i;
  assign gpio_paddr_o   = paddr_i;
  assign gpio_pwrite_o  = pwrite_i;
  assign gpio_pwdata_o  = pwdata_i;

  assign pmx_psel_o    = psel_i & pmx_hit;
  assign pmx_penable_o = penable_i;
  assign pmx_paddr_o   = paddr_i;
  assign pmx_pwrite_o  = pwrite_i;
  assign pmx_pwdata_o  = pwdata_i;

  always_comb begin : resp_mux
    if (gpio_hit) begin
      prdata_o  = gpio_prdata_i;
      pready_o  = gpio_pready_i;
      pslverr_o = gpio_pslverr_i;
    end else if (pmx_hit) begin
      prdata_o  = pmx_prdata_i;
      pready_o  = pmx_pready_i;
      pslverr_o = pmx_pslverr_i;
    end else begin
      // Nothing mapped here, answer with an error
      prdata_o  = '0;
      pready_o  = access;
      pslverr_o = access;
    end
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({gpio_psel_o, pmx_psel_o}));

  // Access phase must follow a setup phase
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(penable_i) |-> psel_i);

endmodule : apb_fabric

`default_nettype wire

/* hdl/gpio_port.sv */
/*
 * GPIO peripheral
 * Data-out and output-enable registers, synchronized input readback over APB
 */
`timescale 1ns/10ps
`default_nettype none

module gpio_port (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  // APB target
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic [chip_pkg::ApbAddrW-1:0] paddr_i,
  input  logic                          pwrite_i,
  input  logic [chip_pkg::ApbDataW-1:0] pwdata_i,
  output logic [chip_pkg::ApbDataW-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,

  // Pin side, through the pinmux
  input  logic [chip_pkg::NGpio-1:0]    gpio_in_i,
  output logic [chip_pkg::NGpio-1:0]    gpio_out_o,
  output logic [chip_pkg::NGpio-1:0]    gpio_oe_o
);

  import chip_pkg::*;

  logic                access;
  logic [TgtOffsW-1:0] offs;
  logic                hit_dout;
  logic                hit_oe;
  logic                hit_din;
  logic                bad_access;
  logic                wr_en;
  logic [NGpio-1:0]    dout_q;
  logic [NGpio-1:0]    oe_q;
  logic [NGpio-1:0]    sync1_q;
  logic [NGpio-1:0]    sync2_q;

  assign access = psel_i & penable_i;
  assign offs   = paddr_i[TgtOffsW-1:0];

  assign hit_dout = (offs == GpioDataOutOffs);
  assign hit_oe   = (offs == GpioOeOffs);
  assign hit_din  = (offs == GpioDataInOffs);

  // Unknown offset, or a write to the read-only input register
  assign bad_access = ~(hit_dout | hit_oe | hit_din) | (pwrite_i & hit_din);
  assign wr_en      = access & pwrite_i & ~bad_access;

  // Zero wait states
  assign pready_o  = access;
  assign pslverr_o = access & bad_access;

  always_comb begin : read_mux
    prdata_o = '0;
    if (hit_dout) begin
      prdata_o = ApbDataW'(dout_q);
    end else if (hit_oe) begin
      prdata_o = ApbDataW'(oe_q);
    end else if (hit_din) begin
      prdata_o = ApbDataW'(sync2_q);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dout_q <= '0;
      oe_q   <= '0;
    end else if (wr_en) begin
      if (hit_dout) begin
        dout_q <= pwdata_i[NGpio-1:0];
      end
      if (hit_oe) begin
        oe_q <= pwdata_i[NGpio-1:0];
      end
    end
  end

  // Pads are asynchronous to clk_i, two flops before software sees them
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
    end
  end

  assign gpio_out_o = dout_q;
  assign gpio_oe_o  = oe_q;

  a_pready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pready_o == (psel_i && penable_i));

endmodule : gpio_port

`default_nettype wire

/* hdl/pinmux_regs.sv */
/*
 * Pinmux register block
 * Per-pad output selects, per-GPIO input selects and a sticky lock
 */
`timescale 1ns/10ps
`default_nettype none

module pinmux_regs (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  // APB target
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic [chip_pkg::ApbAddrW-1:0] paddr_i,
  input  logic                          pwrite_i,
  input  logic [chip_pkg::ApbDataW-1:0] pwdata_i,
  output logic [chip_pkg::ApbDataW-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,

  // Select fields to the pinmux core
  output logic [chip_pkg::NMioPads-1:0][chip_pkg::PadSelW-1:0] mio_outsel_o,
  output logic [chip_pkg::NGpio-1:0][chip_pkg::PadSelW-1:0]    gpio_insel_o
);

  import chip_pkg::*;

  logic                             access;
  logic [TgtOffsW-1:0]              offs;
  logic [NMioPads-1:0]              outsel_hit;
  logic [NGpio-1:0]                 insel_hit;
  logic                             sel_hit;
  logic                             hit_lock;
  logic                             bad_access;
  logic                             wr_en;
  logic                             lock_q;
  logic [NMioPads-1:0][PadSelW-1:0] outsel_q;
  logic [NGpio-1:0][PadSelW-1:0]    insel_q;

  assign access = psel_i & penable_i;
  assign offs   = paddr_i[TgtOffsW-1:0];

  // One-hot decode of the select register arrays
  always_comb begin : decode
    for (int i = 0; i < NMioPads; i++) begin
      outsel_hit[i] = (offs == MioOutselOffs + TgtOffsW'(RegStride * i));
    end
    for (int i = 0; i < NGpio; i++) begin
      insel_hit[i] = (offs == GpioInselOffs + TgtOffsW'(RegStride * i));
    end
  end

  assign sel_hit  = |outsel_hit | |insel_hit;
  assign hit_lock = (offs == LockOffs);

  // LOCK stays writable, selects are refused once locked
  assign bad_access = ~(sel_hit | hit_lock) | (pwrite_i & lock_q & sel_hit);
  assign wr_en      = access & pwrite_i & ~bad_access;

  assign pready_o  = access;
  assign pslverr_o = access & bad_access;

  always_comb begin : read_mux
    prdata_o = '0;
    for (int i = 0; i < NMioPads; i++) begin
      if (outsel_hit[i]) prdata_o = ApbDataW'(outsel_q[i]);
    end
    for (int i = 0; i < NGpio; i++) begin
      if (insel_hit[i]) prdata_o = ApbDataW'(insel_q[i]);
    end
    if (hit_lock) prdata_o = ApbDataW'(lock_q);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outsel_q <= '0;
      insel_q  <= '0;
      lock_q   <= 1'b0;
    end else if (wr_en) begin
      for (int i = 0; i < NMioPads; i++) begin
        if (outsel_hit[i]) outsel_q[i] <= pwdata_i[PadSelW-1:0];
      end
      for (int i = 0; i < NGpio; i++) begin
        if (insel_hit[i]) insel_q[i] <= pwdata_i[PadSelW-1:0];
      end
      // Writing 0 never clears it
      if (hit_lock) lock_q <= lock_q | pwdata_i[0];
    end
  end

  assign mio_outsel_o = outsel_q;
  assign gpio_insel_o = insel_q;

  // Once locked, routing is frozen until reset
  a_lock_frozen: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lock_q |=> ($stable(outsel_q) && $stable(insel_q) && lock_q));

endmodule : pinmux_regs

`default_nettype wire

/* hdl/pinmux_core.sv */
/*
 * Pinmux core
 * Combinational routing of GPIO outputs to pads and pad inputs to GPIO
 */
`timescale 1ns/10ps
`default_nettype none

module pinmux_core (
  // Select fields from the register block
  input  logic [chip_pkg::NMioPads-1:0][chip_pkg::PadSelW-1:0] mio_outsel_i,
  input  logic [chip_pkg::NGpio-1:0][chip_pkg::PadSelW-1:0]    gpio_insel_i,

  // GPIO side
  input  logic [chip_pkg::NGpio-1:0]    gpio_out_i,
  input  logic [chip_pkg::NGpio-1:0]    gpio_oe_i,
  output logic [chip_pkg::NGpio-1:0]    gpio_in_o,

  // Pad side
  input  logic [chip_pkg::NMioPads-1:0] mio_in_i,
  output logic [chip_pkg::NMioPads-1:0] mio_out_o,
  output logic [chip_pkg::NMioPads-1:0] mio_oe_o
);

  import chip_pkg::*;

  // Select names source sel-1 when 1 <= sel <= n
  function automatic logic sel_valid(input logic [PadSelW-1:0] sel, input int n);
    return (sel != '0) && (int'(sel) <= n);
  endfunction

  // Disconnected pads neither drive nor enable
  always_comb begin : out_route
    logic [PadSelW-1:0] src;
    mio_out_o = '0;
    mio_oe_o  = '0;
    for (int p = 0; p < NMioPads; p++) begin
      src = mio_outsel_i[p] - 1'b1;
      if (sel_valid(mio_outsel_i[p], NGpio)) begin
        mio_out_o[p] = gpio_out_i[src[GpioIdxW-1:0]];
        mio_oe_o[p]  = gpio_oe_i[src[GpioIdxW-1:0]];
      end
    end
  end

  // Unrouted GPIO inputs read as 0
  always_comb begin : in_route
    logic [PadSelW-1:0] src;
    gpio_in_o = '0;
    for (int g = 0; g < NGpio; g++) begin
      src = gpio_insel_i[g] - 1'b1;
      if (sel_valid(gpio_insel_i[g], NMioPads)) begin
        gpio_in_o[g] = mio_in_i[src[PadIdxW-1:0]];
      end
    end
  end

  // A pad whose select is out of range must stay tristated
  always_comb begin : oe_check
    for (int p = 0; p < NMioPads; p++) begin
      a_oe_range: assert final (!mio_oe_o[p] ||
                                (mio_outsel_i[p] != '0 && int'(mio_outsel_i[p]) <= NGpio))
        else $error("pad %0d enabled with select %0d", p, mio_outsel_i[p]);
    end
  end

endmodule : pinmux_core

`default_nettype wire

/* hdl/chip_top.sv */
/*
 * Chip-level top
 * APB fabric, GPIO, pinmux registers and pinmux core between APB and pads
 */
`timescale 1ns/10ps
`default_nettype none

module chip_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  // APB
  input  logic [chip_pkg::ApbAddrW-1:0] paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [chip_pkg::ApbDataW-1:0] pwdata_i,
  output logic [chip_pkg::ApbDataW-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,

  // Multiplexed I/O
  input  logic [chip_pkg::NMioPads-1:0] mio_in_i,
  output logic [chip_pkg::NMioPads-1:0] mio_out_o,
  output logic [chip_pkg::NMioPads-1:0] mio_oe_o
);

  import chip_pkg::*;

  // GPIO target bus
  logic                gpio_psel;
  logic                gpio_penable;
  logic [ApbAddrW-1:0] gpio_paddr;
  logic                gpio_pwrite;
  logic [ApbDataW-1:0] gpio_pwdata;
  logic [ApbDataW-1:0] gpio_prdata;
  logic                gpio_pready;
  logic                gpio_pslverr;

  // Pinmux register target bus
  logic                pmx_psel;
  logic                pmx_penable;
  logic [ApbAddrW-1:0] pmx_paddr;
  logic                pmx_pwrite;
  logic [ApbDataW-1:0] pmx_pwdata;
  logic [ApbDataW-1:0] pmx_prdata;
  logic                pmx_pready;
  logic                pmx_pslverr;

  // Routing configuration and GPIO pins
  logic [NMioPads-1:0][PadSelW-1:0] mio_outsel;
  logic [NGpio-1:0][PadSelW-1:0]    gpio_insel;
  logic [NGpio-1:0]                 gpio_out;
  logic [NGpio-1:0]                 gpio_oe;
  logic [NGpio-1:0]                 gpio_in;

  apb_fabric u_fabric (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .gpio_psel_o    (gpio_psel),
    .gpio_penable_o (gpio_penable),
    .gpio_paddr_o   (gpio_paddr),
    .gpio_pwrite_o  (gpio_pwrite),
    .gpio_pwdata_o  (gpio_pwdata),
    .gpio_prdata_i  (gpio_prdata),
    .gpio_pready_i  (gpio_pready),
    .gpio_pslverr_i (gpio_pslverr),
    .pmx_psel_o     (pmx_psel),
    .pmx_penable_o  (pmx_penable),
    .pmx_paddr_o    (pmx_paddr),
    .pmx_pwrite_o   (pmx_pwrite),
    .pmx_pwdata_o   (pmx_pwdata),
    .pmx_prdata_i   (pmx_prdata),
    .pmx_pready_i   (pmx_pready),
    .pmx_pslverr_i  (pmx_pslverr)
  );

  gpio_port u_gpio (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .psel_i     (gpio_psel),
    .penable_i  (gpio_penable),
    .paddr_i    (gpio_paddr),
    .pwrite_i   (gpio_pwrite),
    .pwdata_i   (gpio_pwdata),
    .prdata_o   (gpio_prdata),
    .pready_o   (gpio_pready),
    .pslverr_o  (gpio_pslverr),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (gpio_oe)
  );

  pinmux_regs u_pinmux_regs (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .psel_i       (pmx_psel),
    .penable_i    (pmx_penable),
    .paddr_i      (pmx_paddr),
    .pwrite_i     (pmx_pwrite),
    .pwdata_i     (pmx_pwdata),
    .prdata_o     (pmx_prdata),
    .pready_o     (pmx_pready),
    .pslverr_o    (pmx_pslverr),
    .mio_outsel_o (mio_outsel),
    .gpio_insel_o (gpio_insel)
  );

  pinmux_core u_pinmux_core (
    .mio_outsel_i (mio_outsel),
    .gpio_insel_i (gpio_insel),
    .gpio_out_i   (gpio_out),
    .gpio_oe_i    (gpio_oe),
    .gpio_in_o    (gpio_in),
    .mio_in_i     (mio_in_i),
    .mio_out_o    (mio_out_o),
    .mio_oe_o     (mio_oe_o)
  );

endmodule : chip_top

`default_nettype wire

/* verif/tb_chip_top.sv */
/*
 * Chip subsystem testbench
 * Drives APB and pads, checks routing, readback, error responses and lock
 */
`timescale 1ns/10ps
`default_nettype none

module tb_chip_top;

  import chip_pkg::*;

  localparam int BusTimeout = 16;

  logic                clk = 1'b0;
  logic                arst_n;
  logic [ApbAddrW-1:0] paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [ApbDataW-1:0] pwdata;
  logic [ApbDataW-1:0] prdata;
  logic                pready;
  logic                pslverr;
  logic [NMioPads-1:0] mio_in;
  logic [NMioPads-1:0] mio_out;
  logic [NMioPads-1:0] mio_oe;

  // Reference model of the register state
  logic [NGpio-1:0]    dout_m;
  logic [NGpio-1:0]    oe_m;
  logic [PadSelW-1:0]  outsel_m [NMioPads];
  logic [PadSelW-1:0]  insel_m [NGpio];
  logic                lock_m;
  logic [NMioPads-1:0] exp_out;
  logic [NMioPads-1:0] exp_oe;

  logic [31:0] rng_state = 32'ha098_23c0;
  string       test_name = "init";

  chip_top dut0 (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .mio_in_i  (mio_in),
    .mio_out_o (mio_out),
    .mio_oe_o  (mio_oe)
  );

  initial begin : clock_gen
    forever #10 clk = ~clk;
  end

  // Pads predicted from the output select rule
  always_comb begin : pad_model
    int src;
    exp_out = '0;
    exp_oe  = '0;
    for (int p = 0; p < NMioPads; p++) begin
      src = int'(outsel_m[p]) - 1;
      if (src >= 0 && src < NGpio) begin
        exp_out[p] = dout_m[src];
        exp_oe[p]  = oe_m[src];
      end
    end
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error in %s, %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    abort_run();
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    a_value: assert (act === exp) else value_error(what, exp, act);
  endtask

  a_pad_out: assert property (@(posedge clk) disable iff (!arst_n) mio_out == exp_out)
    else value_error("mio_out", 32'($sampled(exp_out)), 32'($sampled(mio_out)));

  a_pad_oe: assert property (@(posedge clk) disable iff (!arst_n) mio_oe == exp_oe)
    else value_error("mio_oe", 32'($sampled(exp_oe)), 32'($sampled(mio_oe)));

  // Zero wait states, pready high exactly in access phases
  a_zero_wait: assert property (@(posedge clk) disable iff (!arst_n)
    pready == (psel && penable))
    else begin
      $display("APB pready does not match the access phase in %s", test_name);
      abort_run();
    end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [ApbAddrW-1:0] gpio_addr(input int offs);
    return GpioBase | ApbAddrW'(offs);
  endfunction

  function automatic logic [ApbAddrW-1:0] pmx_addr(input int offs);
    return PinmuxBase | ApbAddrW'(offs);
  endfunction

  function automatic logic [ApbAddrW-1:0] outsel_addr(input int i);
    return pmx_addr(int'(MioOutselOffs) + RegStride * i);
  endfunction

  function automatic logic [ApbAddrW-1:0] insel_addr(input int i);
    return pmx_addr(int'(GpioInselOffs) + RegStride * i);
  endfunction

  function automatic void model_clear();
    dout_m = '0;
    oe_m   = '0;
    lock_m = 1'b0;
    for (int i = 0; i < NMioPads; i++) outsel_m[i] = '0;
    for (int i = 0; i < NGpio; i++) insel_m[i] = '0;
  endfunction

  // Error response expected from the address map and the lock
  function automatic logic expect_error(input logic [ApbAddrW-1:0] addr, input logic wr);
    int offs;
    offs = int'(addr[TgtOffsW-1:0]);
    if (addr >= 12'h200) return 1'b1;
    if (!addr[8]) begin
      if (offs == int'(GpioDataInOffs)) return wr;
      return !(offs == int'(GpioDataOutOffs) || offs == int'(GpioOeOffs));
    end
    if (offs == int'(LockOffs)) return 1'b0;
    if (offs % RegStride == 0 && offs < int'(GpioInselOffs) + RegStride * NGpio) begin
      return wr && lock_m;
    end
    return 1'b1;
  endfunction

  function automatic logic [NGpio-1:0] route_in(input logic [NMioPads-1:0] pads);
    logic [NGpio-1:0] res;
    int               src;
    res = '0;
    for (int g = 0; g < NGpio; g++) begin
      src = int'(insel_m[g]) - 1;
      if (src >= 0 && src < NMioPads) res[g] = pads[src];
    end
    return res;
  endfunction

  function automatic void model_write(input logic [ApbAddrW-1:0] addr,
                                      input logic [ApbDataW-1:0] data);
    int offs;
    offs = int'(addr[TgtOffsW-1:0]);
    if (!addr[8]) begin
      if (offs == int'(GpioDataOutOffs)) dout_m = data[NGpio-1:0];
      if (offs == int'(GpioOeOffs)) oe_m = data[NGpio-1:0];
    end else if (offs == int'(LockOffs)) begin
      lock_m = lock_m | data[0];
    end else if (offs < int'(GpioInselOffs)) begin
      outsel_m[(offs - int'(MioOutselOffs)) / RegStride] = data[PadSelW-1:0];
    end else begin
      insel_m[(offs - int'(GpioInselOffs)) / RegStride] = data[PadSelW-1:0];
    end
  endfunction

  // Input readback assumes mio_in has been stable for two edges
  function automatic logic [ApbDataW-1:0] model_read(input logic [ApbAddrW-1:0] addr);
    int offs;
    offs = int'(addr[TgtOffsW-1:0]);
    if (expect_error(addr, 1'b0)) return '0;
    if (!addr[8]) begin
      if (offs == int'(GpioDataOutOffs)) return ApbDataW'(dout_m);
      if (offs == int'(GpioOeOffs)) return ApbDataW'(oe_m);
      return ApbDataW'(route_in(mio_in));
    end
    if (offs == int'(LockOffs)) return ApbDataW'(lock_m);
    if (offs < int'(GpioInselOffs)) return ApbDataW'(outsel_m[offs / RegStride]);
    return ApbDataW'(insel_m[(offs - int'(GpioInselOffs)) / RegStride]);
  endfunction

  // One APB transfer with the response sampled just after the falling edge
  task automatic apb_access(input logic wr, input logic [ApbAddrW-1:0] addr,
                            input logic [ApbDataW-1:0] wdata,
                            output logic [ApbDataW-1:0] rdata, output logic err);
    int cnt;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    cnt = 0;
    while (!pready) begin
      if (cnt == BusTimeout) begin
        $display("Timeout waiting for pready at 0x%03h in %s", addr, test_name);
        abort_run();
      end
      @(negedge clk);
      #1;
      cnt++;
    end
    rdata = prdata;
    err   = pslverr;
    // Access ends at the rising edge in between
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ApbAddrW-1:0] addr, input logic [ApbDataW-1:0] data,
                           input logic exp_err);
    logic [ApbDataW-1:0] rdata;
    logic                err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value($sformatf("pslverr of write to 0x%03h", addr), 32'(exp_err), 32'(err));
  endtask

  task automatic apb_read(input logic [ApbAddrW-1:0] addr, input logic [ApbDataW-1:0] exp_data,
                          input logic exp_err);
    logic [ApbDataW-1:0] rdata;
    logic                err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_value($sformatf("pslverr of read from 0x%03h", addr), 32'(exp_err), 32'(err));
    check_value($sformatf("prdata from 0x%03h", addr), exp_data, rdata);
  endtask

  task automatic reg_write(input logic [ApbAddrW-1:0] addr, input logic [ApbDataW-1:0] data);
    logic err_exp;
    err_exp = expect_error(addr, 1'b1);
    apb_write(addr, data, err_exp);
    if (!err_exp) model_write(addr, data);
  endtask

  task automatic reg_read(input logic [ApbAddrW-1:0] addr);
    apb_read(addr, model_read(addr), expect_error(addr, 1'b0));
  endtask

  task automatic check_all_regs();
    reg_read(gpio_addr(int'(GpioDataOutOffs)));
    reg_read(gpio_addr(int'(GpioOeOffs)));
    for (int i = 0; i < NMioPads; i++) begin
      reg_read(outsel_addr(i));
    end
    for (int i = 0; i < NGpio; i++) begin
      reg_read(insel_addr(i));
    end
    reg_read(pmx_addr(int'(LockOffs)));
    // Last, so a new input select has passed the synchronizer
    reg_read(gpio_addr(int'(GpioDataInOffs)));
  endtask

  task automatic test_reset();
    test_name = "reset state";
    check_value("mio_out", 32'h0, 32'(mio_out));
    check_value("mio_oe", 32'h0, 32'(mio_oe));
    check_all_regs();
  endtask

  task automatic test_out_routing();
    logic [31:0] r;
    test_name = "output routing";
    for (int rnd = 0; rnd < 6; rnd++) begin
      reg_write(gpio_addr(int'(GpioDataOutOffs)), rand32());
      reg_write(gpio_addr(int'(GpioOeOffs)), rand32());
      for (int p = 0; p < NMioPads; p++) begin
        r = rand32();
        // One disconnected and one out-of-range select per round
        if (p == rnd % NMioPads) begin
          r[PadSelW-1:0] = '0;
        end else if (p == (rnd + 1) % NMioPads) begin
          r[PadSelW-1:0] = PadSelW'(9 + r[7:4] % 7);
        end
        reg_write(outsel_addr(p), r);
      end
      repeat (3) @(posedge clk);
    end
  endtask

  task automatic test_in_routing();
    logic [31:0] r;
    test_name = "input routing";
    for (int rnd = 0; rnd < 6; rnd++) begin
      for (int g = 0; g < NGpio; g++) begin
        r = rand32();
        if (g == rnd % NGpio) begin
          r[PadSelW-1:0] = '0;
        end else if (g == (rnd + 1) % NGpio) begin
          r[PadSelW-1:0] = PadSelW'(9 + r[7:4] % 7);
        end
        reg_write(insel_addr(g), r);
      end
      @(negedge clk);
      r = rand32();
      mio_in = r[NMioPads-1:0];
      // Two synchronizer flops plus one edge of margin
      repeat (3) @(posedge clk);
      reg_read(gpio_addr(int'(GpioDataInOffs)));
    end
  endtask

  task automatic test_readback();
    test_name = "register readback";
    for (int rnd = 0; rnd < 3; rnd++) begin
      reg_write(gpio_addr(int'(GpioDataOutOffs)), rand32());
      reg_write(gpio_addr(int'(GpioOeOffs)), rand32());
      for (int p = 0; p < NMioPads; p++) begin
        reg_write(outsel_addr(p), rand32());
      end
      for (int g = 0; g < NGpio; g++) begin
        reg_write(insel_addr(g), rand32());
      end
      check_all_regs();
    end
  endtask

  task automatic test_errors();
    logic [ApbAddrW-1:0] bad_addrs [6];
    logic [ApbAddrW-1:0] addr;
    logic [31:0]         r;
    test_name = "error responses";
    bad_addrs = '{12'h00C, 12'h002, 12'h0FC, 12'h144, 12'h122, 12'h1FC};
    reg_write(gpio_addr(int'(GpioDataInOffs)), rand32());
    for (int i = 0; i < 6; i++) begin
      reg_write(bad_addrs[i], rand32());
      reg_read(bad_addrs[i]);
    end
    // Unmapped space above both targets
    for (int i = 0; i < 8; i++) begin
      r = rand32();
      addr = 12'h200 + 12'(r % 32'hE00);
      reg_write(addr, rand32());
      reg_read(addr);
    end
    check_all_regs();
  endtask

  task automatic test_lock();
    logic [31:0] r;
    test_name = "lock";
    for (int p = 0; p < NMioPads; p++) begin
      reg_write(outsel_addr(p), p + 1);
    end
    reg_write(gpio_addr(int'(GpioOeOffs)), 32'hFF);
    reg_write(pmx_addr(int'(LockOffs)), 32'h1);
    reg_read(pmx_addr(int'(LockOffs)));
    for (int i = 0; i < 8; i++) begin
      r = rand32();
      reg_write(outsel_addr(int'(r % NMioPads)), rand32());
      reg_write(insel_addr(int'((r >> 8) % NGpio)), rand32());
    end
    // Identity routing, so each pad shows its own GPIO bit
    for (int i = 0; i < 6; i++) begin
      reg_write(gpio_addr(int'(GpioDataOutOffs)), rand32());
      check_value("mio_out under lock", 32'(dout_m), 32'(mio_out));
      check_value("mio_oe under lock", 32'hFF, 32'(mio_oe));
    end
    reg_write(pmx_addr(int'(LockOffs)), 32'h0);
    check_all_regs();
  endtask

  initial begin : main
    arst_n  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    mio_in  = '0;
    model_clear();
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    test_reset();
    test_out_routing();
    test_in_routing();
    test_readback();
    test_errors();
    test_lock();
    $display("All tests passed");
    $finish;
  end

endmodule : tb_chip_top

`default_nettype wire

/* vlog.f */
hdl/chip_pkg.sv
hdl/apb_fabric.sv
hdl/gpio_port.sv
hdl/pinmux_regs.sv
hdl/pinmux_core.sv
hdl/chip_top.sv
verif/tb_chip_top.sv

/* Makefile */
# Verilator simulation of the chip subsystem

TOP := tb_chip_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

obj_dir/V$(TOP): vlog.f hdl/*.sv verif/*.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
